/* hw/panel_settings.svh */
`ifndef PANEL_SETTINGS_SVH
`define PANEL_SETTINGS_SVH

// number of BCD digits in the cooking time
`define PANEL_DIGITS 4

// dot matrix is square, rows = columns
`define PANEL_ROWS 8

// clocks per one-second tick, 1 kHz clock
`define PANEL_TICK_DIV 1000

// heating animation length
`define PANEL_HEAT_FRAMES 5

`endif

/* hw/panel_pkg.sv */
package panel_pkg;

    typedef enum logic [1:0]
    {
        IDLE    = 2'd0,
        COOKING = 2'd1,
        PAUSED  = 2'd2,
        DONE    = 2'd3
    } cook_state_e;

    // dot matrix pictures
    typedef enum logic [3:0]
    {
        HEAT0 = 4'd0,
        HEAT1 = 4'd1,
        HEAT2 = 4'd2,
        HEAT3 = 4'd3,
        HEAT4 = 4'd4,
        FULL  = 4'd5,
        BLANK = 4'd15
    } glyph_e;

    typedef struct packed
    {
        logic [3:0] value; // bcd
        logic       zero;
    } digit_view_t;

    typedef struct packed
    {
        logic load;
        logic dec;  // digit 0 only, others take the borrow
    } digit_cmd_t;

endpackage

/* hw/tick_divider.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module tick_divider
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(`PANEL_TICK_DIV)-1:0] cnt;

    // one pulse per PANEL_TICK_DIV clocks
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            if (cnt == `PANEL_TICK_DIV - 1)
            begin
                cnt  <= '0;
                tick <= 1'b1;
            end
            else
            begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

/* hw/cook_control.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module cook_control import panel_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load,
    input  logic                             run,
    input  logic                             tick,
    input  digit_view_t [`PANEL_DIGITS-1:0] digits,
    output digit_cmd_t                       cmd,
    output glyph_e                           glyph,
    output logic                             heating,
    output logic                             done
);

    cook_state_e state, state_next;
    logic [$clog2(`PANEL_HEAT_FRAMES)-1:0] frame, frame_next;
    glyph_e glyph_next;
    logic all_zero;

    always_comb
    begin
        all_zero = 1'b1;
        for (int i = 0; i < `PANEL_DIGITS; i++)
        begin
            all_zero = all_zero & digits[i].zero;
        end
    end

    // no wrap to 9999 once the time has run out
    always_comb
    begin
        cmd.load = load && (state != COOKING);
        cmd.dec  = tick && run && (state == COOKING) && !all_zero;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE, PAUSED:
            begin
                if (load)
                    state_next = IDLE;
                else if (run && !all_zero)
                    state_next = COOKING;
            end
            COOKING:
            begin
                if (all_zero)
                    state_next = DONE;
                else if (!run)
                    state_next = PAUSED;
            end
            DONE:
            begin
                if (load)
                    state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    // animation steps on the second tick while cooking
    always_comb
    begin
        frame_next = '0;
        if (state_next == COOKING)
        begin
            frame_next = frame;
            if (tick && state == COOKING)
                frame_next = (frame == `PANEL_HEAT_FRAMES - 1) ? '0 : frame + 1'b1;
        end
        case (state_next)
            COOKING: glyph_next = glyph_e'(4'(frame_next));
            DONE:    glyph_next = FULL;
            default: glyph_next = BLANK;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= IDLE;
            frame <= '0;
            glyph <= BLANK;
        end
        else
        begin
            state <= state_next;
            frame <= frame_next;
            glyph <= glyph_next;
        end
    end

    assign heating = (state == COOKING);
    assign done    = (state == DONE);

endmodule

/* hw/bcd_down_digit.sv */
`timescale 1ns/1ps

module bcd_down_digit import panel_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_load,
    input  logic [3:0]  load_value,
    input  logic        dec,
    output digit_view_t view,
    output logic        borrow
);

    logic [3:0] value;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            value <= 4'd0;
        else if (cmd_load)
            value <= load_value;
        else if (dec)
        begin
            if (value == 4'd0)
                value <= 4'd9; // wrap, borrow goes up
            else
                value <= value - 4'd1;
        end
    end

    // ripples through the chain in the same cycle
    assign borrow = dec && (value == 4'd0);

    always_comb
    begin
        view.value = value;
        view.zero  = (value == 4'd0);
    end

endmodule

/* hw/seg_scan.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module seg_scan import panel_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst,
    input  digit_view_t [`PANEL_DIGITS-1:0] digits,
    output logic [7:0]                       seg,
    output logic [`PANEL_DIGITS-1:0]         dig_sel
);

    logic [$clog2(`PANEL_DIGITS)-1:0] scan;

    // segments g..a, dp stays dark
    function automatic logic [7:0] bcd_to_seg(input logic [3:0] bcd);
        logic [7:0] pat;
        case (bcd)
            4'd0:    pat = 8'b0011_1111;
            4'd1:    pat = 8'b0000_0110;
            4'd2:    pat = 8'b0101_1011;
            4'd3:    pat = 8'b0100_1111;
            4'd4:    pat = 8'b0110_0110;
            4'd5:    pat = 8'b0110_1101;
            4'd6:    pat = 8'b0111_1101;
            4'd7:    pat = 8'b0000_0111;
            4'd8:    pat = 8'b0111_1111;
            4'd9:    pat = 8'b0110_1111;
            default: pat = 8'b0000_0000; // not bcd
        endcase
        return pat;
    endfunction

    // seg and dig_sel registered together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan    <= '0;
            seg     <= 8'b0;
            dig_sel <= '1;
        end
        else
        begin
            seg     <= bcd_to_seg(digits[scan].value);
            dig_sel <= ~(`PANEL_DIGITS'(1) << scan); // active low
            if (scan == `PANEL_DIGITS - 1)
                scan <= '0;
            else
                scan <= scan + 1'b1;
        end
    end

endmodule

/* hw/dot_matrix_scan.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module dot_matrix_scan import panel_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  glyph_e                 glyph,
    input  logic                   heating,
    output logic [`PANEL_ROWS-1:0] row,
    output logic [`PANEL_ROWS-1:0] colg,
    output logic [`PANEL_ROWS-1:0] colr
);

    logic [$clog2(`PANEL_ROWS)-1:0] row_cnt;
    glyph_e glyph_q;

    // green pattern per glyph and row, row 0 on top
    function automatic logic [`PANEL_ROWS-1:0] glyph_row(
        input glyph_e                         g,
        input logic [$clog2(`PANEL_ROWS)-1:0] r
    );
        logic [`PANEL_ROWS-1:0] pat;
        pat = '0;
        case (g)
            HEAT0:
            begin
                case (r)
                    3'd6: pat = 8'b0001_1000;
                    3'd7: pat = 8'b0011_1100;
                    default: pat = '0;
                endcase
            end
            HEAT1:
            begin
                case (r)
                    3'd5: pat = 8'b0001_0000;
                    3'd6: pat = 8'b0011_1000;
                    3'd7: pat = 8'b0111_1100;
                    default: pat = '0;
                endcase
            end
            HEAT2:
            begin
                case (r)
                    3'd4: pat = 8'b0000_1000;
                    3'd5: pat = 8'b0001_1000;
                    3'd6: pat = 8'b0011_1100;
                    3'd7: pat = 8'b0111_1110;
                    default: pat = '0;
                endcase
            end
            HEAT3:
            begin
                case (r)
                    3'd3: pat = 8'b0001_0000;
                    3'd4: pat = 8'b0001_1000;
                    3'd5: pat = 8'b0011_1100;
                    3'd6, 3'd7: pat = 8'b0111_1110;
                    default: pat = '0;
                endcase
            end
            HEAT4:
            begin
                case (r)
                    3'd1: pat = 8'b0000_1000;
                    3'd2: pat = 8'b0001_0000;
                    3'd3: pat = 8'b0001_1000;
                    3'd4: pat = 8'b0011_1100;
                    3'd5: pat = 8'b0111_1110;
                    3'd6, 3'd7: pat = 8'b1111_1111;
                    default: pat = '0;
                endcase
            end
            FULL:    pat = '1;
            default: pat = '0;
        endcase
        return pat;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_cnt <= '0;
            glyph_q <= BLANK;
            row     <= '1;
            colg    <= '0;
        end
        else
        begin
            glyph_q <= glyph;
            row_cnt <= row_cnt + 1'b1; // wraps after the last row
            row     <= ~(`PANEL_ROWS'(1) << row_cnt);
            colg    <= glyph_row(glyph_q, row_cnt); // same row as row
        end
    end

    // red mirrors green only with the heater on
    assign colr = heating ? colg : '0;

endmodule

/* hw/heater_panel_top.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module heater_panel_top import panel_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [4*`PANEL_DIGITS-1:0] preset,
    input  logic                     load,
    input  logic                     run,
    output logic [`PANEL_ROWS-1:0]   row,
    output logic [`PANEL_ROWS-1:0]   colg,
    output logic [`PANEL_ROWS-1:0]   colr,
    output logic [7:0]               seg,
    output logic [`PANEL_DIGITS-1:0] dig_sel,
    output logic                     heating,
    output logic                     done
);

    logic tick;
    digit_cmd_t cmd;
    glyph_e glyph;
    digit_view_t [`PANEL_DIGITS-1:0] views;
    logic [`PANEL_DIGITS:0] dec_chain; // top bit is the overflow borrow

    tick_divider u_tick_divider
    (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    cook_control u_cook_control
    (
        .clk     (clk),
        .rst     (rst),
        .load    (load),
        .run     (run),
        .tick    (tick),
        .digits  (views),
        .cmd     (cmd),
        .glyph   (glyph),
        .heating (heating),
        .done    (done)
    );

    assign dec_chain[0] = cmd.dec;

    // digit 0 in the low nibble
    for (genvar i = 0; i < `PANEL_DIGITS; i++)
    begin : g_digit
        bcd_down_digit u_digit
        (
            .clk        (clk),
            .rst        (rst),
            .cmd_load   (cmd.load),
            .load_value (preset[4*i +: 4]),
            .dec        (dec_chain[i]),
            .view       (views[i]),
            .borrow     (dec_chain[i+1])
        );
    end

    seg_scan u_seg_scan
    (
        .clk     (clk),
        .rst     (rst),
        .digits  (views),
        .seg     (seg),
        .dig_sel (dig_sel)
    );

    dot_matrix_scan u_dot_matrix_scan
    (
        .clk     (clk),
        .rst     (rst),
        .glyph   (glyph),
        .heating (heating),
        .row     (row),
        .colg    (colg),
        .colr    (colr)
    );

endmodule

/* verification/heater_panel_sva.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module heater_panel_sva
(
    input logic                   clk,
    input logic                   rst,
    input logic [`PANEL_ROWS-1:0] row,
    input logic [`PANEL_ROWS-1:0] colr,
    input logic                   heating,
    input logic                   done
);

    int fail_count = 0; // failed assertions so far

    // one row lit at a time once the scanner has left reset
    property one_row_active;
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> $countones(~row) == 1;
    endproperty

    assert property (one_row_active)
    else
    begin
        $error("row is not an active-low one-hot code");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst) !(heating && done))
    else
    begin
        $error("heating and done are high together");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (rst) !heating |-> colr == '0)
    else
    begin
        $error("red columns lit with the heater off");
        fail_count++;
    end

endmodule

bind heater_panel_top heater_panel_sva u_heater_panel_sva (.*);

/* verification/heater_panel_tb.sv */
`timescale 1ns/1ps
`include "panel_settings.svh"

module heater_panel_tb;

    // one-second ticks waited per test in run order
    localparam int TICK_BUDGET = 2 + 4 + 2 + 6 + 1;

    logic                        clk;
    logic                        rst;
    logic [4*`PANEL_DIGITS-1:0]  preset;
    logic                        load;
    logic                        run;
    logic [`PANEL_ROWS-1:0]      row;
    logic [`PANEL_ROWS-1:0]      colg;
    logic [`PANEL_ROWS-1:0]      colr;
    logic [7:0]                  seg;
    logic [`PANEL_DIGITS-1:0]    dig_sel;
    logic                        heating;
    logic                        done;
    integer                      seed;

    heater_panel_top u_heater_panel_top
    (
        .clk     (clk),
        .rst     (rst),
        .preset  (preset),
        .load    (load),
        .run     (run),
        .row     (row),
        .colg    (colg),
        .colr    (colr),
        .seg     (seg),
        .dig_sel (dig_sel),
        .heating (heating),
        .done    (done)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            abort_run();
        end
    endtask

    // segments a..g on bits 0..6
    function automatic logic [7:0] seg_pattern(input logic [3:0] bcd);
        case (bcd)
            4'd0:    return 8'h3f;
            4'd1:    return 8'h06;
            4'd2:    return 8'h5b;
            4'd3:    return 8'h4f;
            4'd4:    return 8'h66;
            4'd5:    return 8'h6d;
            4'd6:    return 8'h7d;
            4'd7:    return 8'h07;
            4'd8:    return 8'h7f;
            4'd9:    return 8'h6f;
            default: return 8'h00;
        endcase
    endfunction

    // returns on the falling edge where the one-second tick is seen
    task automatic wait_tick();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!u_heater_panel_top.tick && n <= `PANEL_TICK_DIV);
        assert (u_heater_panel_top.tick)
        else
        begin
            $display("no one-second tick within %0d clocks", `PANEL_TICK_DIV);
            abort_run();
        end
    endtask

    // load is ignored while cooking so pause first
    task automatic load_preset(input logic [4*`PANEL_DIGITS-1:0] value);
        run = 1'b0;
        repeat (2) @(negedge clk);
        wait_tick();
        preset = value;
        load   = 1'b1;
        @(negedge clk);
        load   = 1'b0;
    endtask

    // every selected digit against its preset nibble over one full scan
    task automatic compare_display(input string name, input logic [4*`PANEL_DIGITS-1:0] value);
        logic [`PANEL_DIGITS-1:0] seen;
        int idx;
        seen = '0;
        repeat (`PANEL_DIGITS)
        begin
            @(negedge clk);
            idx = -1;
            for (int i = 0; i < `PANEL_DIGITS; i++)
                if (dig_sel == ~(`PANEL_DIGITS'(1) << i))
                    idx = i;
            assert (idx >= 0)
            else
            begin
                $display("dig_sel %b selects no single digit", dig_sel);
                abort_run();
            end
            expect_equal(name, seg_pattern(value[4*idx +: 4]), seg);
            seen[idx] = 1'b1;
        end
        expect_equal({name, " digits scanned"}, {`PANEL_DIGITS{1'b1}}, seen);
    endtask

    task automatic reset_state();
        logic [`PANEL_DIGITS-1:0] exp_sel;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_equal("reset row", 8'hff, row);
        expect_equal("reset colg", 0, colg);
        expect_equal("reset colr", 0, colr);
        expect_equal("reset seg", 0, seg);
        expect_equal("reset dig_sel", 4'hf, dig_sel);
        expect_equal("reset heating", 0, heating);
        expect_equal("reset done", 0, done);
        rst = 1'b0;
        for (int i = 0; i < 2*`PANEL_DIGITS; i++)
        begin
            @(negedge clk);
            exp_sel = ~(`PANEL_DIGITS'(1) << (i % `PANEL_DIGITS));
            expect_equal("reset dig_sel rotation", exp_sel, dig_sel);
        end
    endtask

    task automatic load_and_display();
        logic [4*`PANEL_DIGITS-1:0] value;
        repeat (2)
        begin
            for (int i = 0; i < `PANEL_DIGITS; i++)
                value[4*i +: 4] = 4'($unsigned($random(seed)) % 10);
            load_preset(value);
            repeat (2) @(negedge clk);
            compare_display("load and display", value);
        end
    endtask

    task automatic countdown_to_done();
        int n;
        load_preset(16'h0003);
        run = 1'b1;
        repeat (2) @(negedge clk);
        expect_equal("countdown heating", 1, heating);
        expect_equal("countdown done early", 0, done);
        for (int k = 2; k >= 1; k--)
        begin
            wait_tick();
            repeat (2) @(negedge clk);
            compare_display("countdown", 16'(k));
        end
        wait_tick();
        n = 0;
        while (!done && n < 2)
        begin
            @(negedge clk);
            n++;
        end
        expect_equal("countdown done", 1, done);
        expect_equal("countdown heating off", 0, heating);
        repeat (3) @(negedge clk); // glyph reaches colg two stages later
        for (int r = 0; r < `PANEL_ROWS; r++)
        begin
            @(negedge clk);
            expect_equal("done glyph colg", 8'hff, colg);
        end
        compare_display("countdown end", 16'h0000);
    endtask

    task automatic borrow_across_digits();
        load_preset(16'h0100);
        run = 1'b1;
        wait_tick();
        repeat (2) @(negedge clk);
        compare_display("borrow across digits", 16'h0099);
    endtask

    task automatic pause_resume();
        load_preset(16'h0050);
        run = 1'b1;
        wait_tick();
        repeat (2) @(negedge clk);
        compare_display("pause start", 16'h0049);
        run = 1'b0;
        repeat (3)
        begin
            wait_tick();
            repeat (2) @(negedge clk);
            compare_display("pause hold", 16'h0049);
        end
        for (int r = 0; r < `PANEL_ROWS; r++)
        begin
            @(negedge clk);
            expect_equal("pause colg", 0, colg);
        end
        run = 1'b1;
        wait_tick();
        repeat (2) @(negedge clk);
        compare_display("pause resume", 16'h0048);
    endtask

    task automatic matrix_scan();
        logic [`PANEL_ROWS-1:0] exp_row;
        logic [`PANEL_ROWS-1:0] lit;
        int idx;
        load_preset(16'h0020);
        run = 1'b1;
        repeat (4) @(negedge clk);
        expect_equal("matrix heating", 1, heating);
        idx = -1;
        for (int i = 0; i < `PANEL_ROWS; i++)
            if (row == ~(`PANEL_ROWS'(1) << i))
                idx = i;
        assert (idx >= 0)
        else
        begin
            $display("row %b is not an active-low one-hot code", row);
            abort_run();
        end
        lit = '0;
        repeat (2*`PANEL_ROWS)
        begin
            @(negedge clk);
            idx = (idx + 1) % `PANEL_ROWS;
            exp_row = ~(`PANEL_ROWS'(1) << idx);
            expect_equal("matrix row", exp_row, row);
            expect_equal("matrix colr", colg, colr);
            lit |= colg;
        end
        assert (lit != '0)
        else
        begin
            $display("colg stayed dark over two full scans while cooking");
            abort_run();
        end
        run = 1'b0;
    endtask

    initial
    begin
        #((TICK_BUDGET + 2) * `PANEL_TICK_DIV * 10);
        $display("watchdog timeout, the tests did not finish in time");
        abort_run();
    end

    initial
    begin
        wait (u_heater_panel_top.u_heater_panel_sva.fail_count != 0);
        $display("a bound assertion on the DUT outputs failed");
        abort_run();
    end

    initial
    begin
        clk    = 1'b0;
        rst    = 1'b1;
        preset = '0;
        load   = 1'b0;
        run    = 1'b0;
        seed   = 47;
        reset_state();
        load_and_display();
        countdown_to_done();
        borrow_across_digits();
        pause_resume();
        matrix_scan();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+hw
hw/panel_pkg.sv
hw/tick_divider.sv
hw/cook_control.sv
hw/bcd_down_digit.sv
hw/seg_scan.sv
hw/dot_matrix_scan.sv
hw/heater_panel_top.sv
verification/heater_panel_sva.sv
verification/heater_panel_tb.sv
